/* Makefile */
# Verilator build and run for the integer execution unit
# Override any variable on the command line, e.g. make run JOBS=8

VERILATOR ?= verilator
TOP       ?= alu_exec_unit_tb
FILELIST  ?= alu_exec_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= TEST PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the log holds the pass line
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* alu_exec_unit.f */
src/alu_pkg.sv
src/alu_issue_queue.sv
src/spill_cell_flush.sv
src/alu.sv
src/alu_exec_unit.sv
tb/alu_exec_unit_tb.sv

/* src/alu.sv */
// --------------------------------------------------------------------------
// Integer ALU datapath for RV64
// Combinational from the queue head into a flushable output spill cell
// SKIP_REG removes the output register
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module alu #(
  parameter bit SKIP_REG = 1'b0
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     flush_i,
  // Operation from the issue queue
  input  logic                     valid_i,
  output logic                     ready_o,
  input  alu_pkg::alu_op_t         op_i,
  input  alu_pkg::rob_idx_t        rob_idx_i,
  input  logic [alu_pkg::XLEN-1:0] rs1_i,
  input  logic [alu_pkg::XLEN-1:0] rs2_i,
  // Result
  output logic                     valid_o,
  input  logic                     ready_i,
  output alu_pkg::rob_idx_t        rob_idx_o,
  output logic [alu_pkg::XLEN-1:0] result_o,
  output logic                     except_raised_o,
  output alu_pkg::except_code_t    except_code_o
);

  localparam int unsigned XLEN    = alu_pkg::XLEN;
  localparam int unsigned HALF    = XLEN / 2;
  localparam int unsigned SHAMT_W = $clog2(XLEN);
  localparam int unsigned SHW_W   = $clog2(HALF);

  // Payload carried through the output register
  typedef struct packed {
    logic [XLEN-1:0]   res;
    alu_pkg::rob_idx_t rob_idx;
    logic              except_raised;
  } out_data_t;

  function automatic logic [XLEN-1:0] reverse_bits(input logic [XLEN-1:0] a);
    logic [XLEN-1:0] r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = a[XLEN-1-i];
    end
    return r;
  endfunction

  // Sign-extend the low word
  function automatic logic [XLEN-1:0] sext_w(input logic [XLEN-1:0] a);
    return {{HALF{a[HALF-1]}}, a[HALF-1:0]};
  endfunction

  logic [XLEN-1:0]    rs1_w;
  logic [XLEN-1:0]    rs2_w;
  logic [XLEN-1:0]    adder_a;
  logic [XLEN-1:0]    adder_b;
  logic               adder_cin;
  logic [XLEN-1:0]    adder_res;
  logic               lt_signed;
  logic               lt_unsigned;
  logic [XLEN:0]      shifter_a;
  logic [SHAMT_W-1:0] shifter_shamt;
  logic [XLEN:0]      shifter_res;
  logic [XLEN-1:0]    shifter_res_rev;
  logic [XLEN-1:0]    shift_w_src;
  logic [XLEN-1:0]    result;
  logic               except_raised;
  out_data_t          out_d;
  out_data_t          out_q;

  // --------------------------------------------------------------------------
  // Adder and comparisons
  // --------------------------------------------------------------------------
  assign rs1_w = sext_w(rs1_i);
  assign rs2_w = sext_w(rs2_i);

  // Subtraction as rs1 + ~rs2 + 1
  always_comb begin
    adder_a   = rs1_i;
    adder_b   = rs2_i;
    adder_cin = 1'b0;
    unique case (op_i)
      alu_pkg::ALU_SUB, alu_pkg::ALU_SLT, alu_pkg::ALU_SLTU: begin
        adder_b   = ~rs2_i;
        adder_cin = 1'b1;
      end
      alu_pkg::ALU_ADDW: begin
        adder_a = rs1_w;
        adder_b = rs2_w;
      end
      alu_pkg::ALU_SUBW: begin
        adder_a   = rs1_w;
        adder_b   = ~rs2_w;
        adder_cin = 1'b1;
      end
      default: ;
    endcase
  end

  assign adder_res = adder_a + adder_b + {{(XLEN-1){1'b0}}, adder_cin};

  // Differing signs decide directly
  // otherwise the sign of the difference does
  assign lt_signed   = (rs1_i[XLEN-1] != rs2_i[XLEN-1]) ? rs1_i[XLEN-1] : adder_res[XLEN-1];
  assign lt_unsigned = (rs1_i[XLEN-1] != rs2_i[XLEN-1]) ? rs2_i[XLEN-1] : adder_res[XLEN-1];

  // --------------------------------------------------------------------------
  // Shifter
  // --------------------------------------------------------------------------
  // Extra top bit carries the fill value
  always_comb begin
    unique case (op_i)
      alu_pkg::ALU_SRL:  shifter_a = {1'b0, rs1_i};
      alu_pkg::ALU_SRA:  shifter_a = {rs1_i[XLEN-1], rs1_i};
      alu_pkg::ALU_SRLW: shifter_a = {{(HALF+1){1'b0}}, rs1_i[HALF-1:0]};
      alu_pkg::ALU_SRAW: shifter_a = {{(HALF+1){rs1_i[HALF-1]}}, rs1_i[HALF-1:0]};
      // Left shifts go in reversed
      default:           shifter_a = {1'b0, reverse_bits(rs1_i)};
    endcase
  end

  // W shifts use 5 bits of shift amount
  always_comb begin
    unique case (op_i)
      alu_pkg::ALU_SLLW, alu_pkg::ALU_SRLW, alu_pkg::ALU_SRAW:
        shifter_shamt = {{(SHAMT_W-SHW_W){1'b0}}, rs2_i[SHW_W-1:0]};
      default:
        shifter_shamt = rs2_i[SHAMT_W-1:0];
    endcase
  end

  assign shifter_res     = $unsigned($signed(shifter_a) >>> shifter_shamt);
  assign shifter_res_rev = reverse_bits(shifter_res[XLEN-1:0]);
  assign shift_w_src     = (op_i == alu_pkg::ALU_SLLW) ? shifter_res_rev
                                                       : shifter_res[XLEN-1:0];

  // --------------------------------------------------------------------------
  // Result multiplexer
  // --------------------------------------------------------------------------
  always_comb begin
    result        = '0;
    except_raised = 1'b0;
    unique case (op_i)
      alu_pkg::ALU_ADD, alu_pkg::ALU_SUB:   result = adder_res;
      alu_pkg::ALU_ADDW, alu_pkg::ALU_SUBW: result = sext_w(adder_res);
      alu_pkg::ALU_AND:                     result = rs1_i & rs2_i;
      alu_pkg::ALU_OR:                      result = rs1_i | rs2_i;
      alu_pkg::ALU_XOR:                     result = rs1_i ^ rs2_i;
      alu_pkg::ALU_SLL:                     result = shifter_res_rev;
      alu_pkg::ALU_SRL, alu_pkg::ALU_SRA:   result = shifter_res[XLEN-1:0];
      alu_pkg::ALU_SLLW, alu_pkg::ALU_SRLW, alu_pkg::ALU_SRAW:
        result = sext_w(shift_w_src);
      alu_pkg::ALU_SLT:                     result = {{(XLEN-1){1'b0}}, lt_signed};
      alu_pkg::ALU_SLTU:                    result = {{(XLEN-1){1'b0}}, lt_unsigned};
      // Unassigned opcode
      default:                              except_raised = 1'b1;
    endcase
  end

  // --------------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------------
  assign out_d.res           = result;
  assign out_d.rob_idx       = rob_idx_i;
  assign out_d.except_raised = except_raised;

  spill_cell_flush #(
    .DATA_T  (out_data_t),
    .SKIP_REG(SKIP_REG)
  ) u_out_reg (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .flush_i (flush_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (out_d),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (out_q)
  );

  assign result_o        = out_q.res;
  assign rob_idx_o       = out_q.rob_idx;
  assign except_raised_o = out_q.except_raised;
  // Only exception this unit can raise
  assign except_code_o   = alu_pkg::E_ILLEGAL_INSTRUCTION;

endmodule

/* src/alu_exec_unit.sv */
// --------------------------------------------------------------------------
// Integer execution unit top level
// Issue queue feeding the ALU with valid/ready at both ends
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module alu_exec_unit #(
  parameter int unsigned QUEUE_DEPTH = 4,
  parameter bit          SKIP_REG    = 1'b0
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     flush_i,
  // Issue side
  input  logic                     valid_i,
  output logic                     ready_o,
  input  alu_pkg::alu_op_t         op_i,
  input  alu_pkg::rob_idx_t        rob_idx_i,
  input  logic [alu_pkg::XLEN-1:0] rs1_i,
  input  logic [alu_pkg::XLEN-1:0] rs2_i,
  // Result side
  output logic                     valid_o,
  input  logic                     ready_i,
  output alu_pkg::rob_idx_t        rob_idx_o,
  output logic [alu_pkg::XLEN-1:0] result_o,
  output logic                     except_raised_o,
  output alu_pkg::except_code_t    except_code_o
);

  // Queue head into the ALU
  logic                     q_valid;
  logic                     q_ready;
  alu_pkg::alu_op_t         q_op;
  alu_pkg::rob_idx_t        q_rob_idx;
  logic [alu_pkg::XLEN-1:0] q_rs1;
  logic [alu_pkg::XLEN-1:0] q_rs2;

  alu_issue_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_issue_queue (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .op_i     (op_i),
    .rob_idx_i(rob_idx_i),
    .rs1_i    (rs1_i),
    .rs2_i    (rs2_i),
    .valid_o  (q_valid),
    .ready_i  (q_ready),
    .op_o     (q_op),
    .rob_idx_o(q_rob_idx),
    .rs1_o    (q_rs1),
    .rs2_o    (q_rs2)
  );

  alu #(
    .SKIP_REG(SKIP_REG)
  ) u_alu (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .flush_i        (flush_i),
    .valid_i        (q_valid),
    .ready_o        (q_ready),
    .op_i           (q_op),
    .rob_idx_i      (q_rob_idx),
    .rs1_i          (q_rs1),
    .rs2_i          (q_rs2),
    .valid_o        (valid_o),
    .ready_i        (ready_i),
    .rob_idx_o      (rob_idx_o),
    .result_o       (result_o),
    .except_raised_o(except_raised_o),
    .except_code_o  (except_code_o)
  );

endmodule

/* src/alu_issue_queue.sv */
// --------------------------------------------------------------------------
// Issue queue in front of the ALU
// Circular FIFO with flush and valid/ready on both sides
// QUEUE_DEPTH must be a power of two and at least 2
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module alu_issue_queue #(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     flush_i,
  // Issue side
  input  logic                     valid_i,
  output logic                     ready_o,
  input  alu_pkg::alu_op_t         op_i,
  input  alu_pkg::rob_idx_t        rob_idx_i,
  input  logic [alu_pkg::XLEN-1:0] rs1_i,
  input  logic [alu_pkg::XLEN-1:0] rs2_i,
  // ALU side
  output logic                     valid_o,
  input  logic                     ready_i,
  output alu_pkg::alu_op_t         op_o,
  output alu_pkg::rob_idx_t        rob_idx_o,
  output logic [alu_pkg::XLEN-1:0] rs1_o,
  output logic [alu_pkg::XLEN-1:0] rs2_o
);

  localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(QUEUE_DEPTH);

  // Entry storage
  alu_pkg::alu_op_t         op_mem  [QUEUE_DEPTH];
  alu_pkg::rob_idx_t        rob_mem [QUEUE_DEPTH];
  logic [alu_pkg::XLEN-1:0] rs1_mem [QUEUE_DEPTH];
  logic [alu_pkg::XLEN-1:0] rs2_mem [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             push;
  logic             pop;

  // Nothing enters during a flush
  assign push = valid_i & ready_o & ~flush_i;
  assign pop  = valid_o & ready_i;

  // Handshake from occupancy only
  assign ready_o = (count_q != FULL_CNT);
  assign valid_o = (count_q != '0);

  // --------------------------------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap on their own width
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  // Payload write
  always_ff @(posedge clk_i) begin
    if (push) begin
      op_mem[wr_ptr_q]  <= op_i;
      rob_mem[wr_ptr_q] <= rob_idx_i;
      rs1_mem[wr_ptr_q] <= rs1_i;
      rs2_mem[wr_ptr_q] <= rs2_i;
    end
  end

  // Head of queue
  assign op_o      = op_mem[rd_ptr_q];
  assign rob_idx_o = rob_mem[rd_ptr_q];
  assign rs1_o     = rs1_mem[rd_ptr_q];
  assign rs2_o     = rs2_mem[rd_ptr_q];

  // Occupancy never runs past the depth
  // and always matches the distance between the pointers
  a_count_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    count_q <= FULL_CNT && count_q[PTR_W-1:0] == (wr_ptr_q - rd_ptr_q));

  // Filling the last slot closes the issue side on the next cycle
  a_full_backpressure: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (count_q == FULL_CNT - 1'b1 && push && !pop) |=> !ready_o);

endmodule

/* src/alu_pkg.sv */
// --------------------------------------------------------------------------
// Shared definitions for the integer execution unit
// Queue, ALU and top level reach them by scoped names
// --------------------------------------------------------------------------
package alu_pkg;

  // Data word width
  // W operations work on the 32-bit halves of this word
  localparam int unsigned XLEN = 64;

  // Reorder buffer index width
  localparam int unsigned ROB_IDX_W = 4;

  // ALU opcodes
  // Code 15 is left unassigned and decodes as illegal
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_ADDW = 4'd2,
    ALU_SUBW = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9,
    ALU_SLLW = 4'd10,
    ALU_SRLW = 4'd11,
    ALU_SRAW = 4'd12,
    ALU_SLT  = 4'd13,
    ALU_SLTU = 4'd14
  } alu_op_t;

  // Reorder buffer index
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // Exception codes
  // Numbering follows the RISC-V mcause values
  typedef enum logic [3:0] {
    E_I_ADDR_MISALIGNED   = 4'h0,
    E_I_ACCESS_FAULT      = 4'h1,
    E_ILLEGAL_INSTRUCTION = 4'h2,
    E_BREAKPOINT          = 4'h3,
    E_LD_ADDR_MISALIGNED  = 4'h4,
    E_LD_ACCESS_FAULT     = 4'h5,
    E_ST_ADDR_MISALIGNED  = 4'h6,
    E_ST_ACCESS_FAULT     = 4'h7
  } except_code_t;

endpackage

/* src/spill_cell_flush.sv */
// --------------------------------------------------------------------------
// Two-entry spill register with flush
// Cuts the ready path between its two sides
// SKIP_REG turns it into a plain pass-through
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module spill_cell_flush #(
  parameter type DATA_T   = logic,
  parameter bit  SKIP_REG = 1'b0
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  flush_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  DATA_T data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output DATA_T data_o
);

  if (SKIP_REG) begin : gen_skip
    // Combinational path
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_reg
    logic  a_full_q;
    logic  b_full_q;
    DATA_T a_data_q;
    DATA_T b_data_q;
    logic  a_fill;
    logic  a_drain;
    logic  b_fill;
    logic  b_drain;

    // Main register takes new data
    // and empties to the output or into the spill slot
    assign a_fill  = valid_i & ready_o;
    assign a_drain = a_full_q & ~b_full_q;
    // Spill slot catches a stalled main entry
    assign b_fill  = a_drain & ~ready_i;
    assign b_drain = b_full_q & ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else if (flush_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) a_full_q <= a_fill;
        if (b_fill || b_drain) b_full_q <= b_fill;
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) a_data_q <= data_i;
      if (b_fill) b_data_q <= a_data_q;
    end

    // Spill slot always holds the older entry
    assign valid_o = a_full_q | b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
    assign ready_o = ~b_full_q;

    // Stalled output holds until taken or flushed
    a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (valid_o && !ready_i && !flush_i) |=> (valid_o && $stable(data_o)));
  end

endmodule

/* tb/alu_exec_unit_tb.sv */
// --------------------------------------------------------------------------
// Testbench for the integer execution unit
// Streams golden vectors into the issue side under random output stalls
// and checks every result, rob index and exception flag in issue order
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module alu_exec_unit_tb;

  localparam int unsigned XLEN           = alu_pkg::XLEN;
  localparam int unsigned ACCEPT_TIMEOUT = 200;
  localparam int unsigned DRAIN_TIMEOUT  = 400;
  localparam int unsigned SETTLE_CYCLES  = 10;
  localparam logic [31:0] RAND_SEED      = 32'heacd_a0f2;

  // Expected outcome of one issued operation
  typedef struct {
    logic [XLEN-1:0]   res;
    alu_pkg::rob_idx_t rob_idx;
    logic              except_raised;
  } expect_t;

  logic                  clk_i = 1'b0;
  logic                  arst_n_i;
  logic                  flush_i;
  logic                  valid_i;
  logic                  ready_o;
  alu_pkg::alu_op_t      op_i;
  alu_pkg::rob_idx_t     rob_idx_i;
  logic [XLEN-1:0]       rs1_i;
  logic [XLEN-1:0]       rs2_i;
  logic                  valid_o;
  logic                  ready_i;
  alu_pkg::rob_idx_t     rob_idx_o;
  logic [XLEN-1:0]       result_o;
  logic                  except_raised_o;
  alu_pkg::except_code_t except_code_o;

  // Scoreboard, appended by the driver only
  expect_t           exp_q[$];
  // Entries below skip_to were discarded by a flush
  int unsigned       skip_to       = 0;
  // Next entry the monitor compares against
  int unsigned       chk_idx       = 0;
  int unsigned       checked_cnt   = 0;
  int unsigned       mismatch_cnt  = 0;
  int unsigned       extra_cnt     = 0;
  int unsigned       state_err_cnt = 0;
  int unsigned       timeout_cnt   = 0;
  int unsigned       io_err_cnt    = 0;
  alu_pkg::rob_idx_t rob_ctr;

  always #5 clk_i = ~clk_i;

  alu_exec_unit #(
    .QUEUE_DEPTH(4),
    .SKIP_REG   (1'b0)
  ) DUT (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .flush_i        (flush_i),
    .valid_i        (valid_i),
    .ready_o        (ready_o),
    .op_i           (op_i),
    .rob_idx_i      (rob_idx_i),
    .rs1_i          (rs1_i),
    .rs2_i          (rs2_i),
    .valid_o        (valid_o),
    .ready_i        (ready_i),
    .rob_idx_o      (rob_idx_o),
    .result_o       (result_o),
    .except_raised_o(except_raised_o),
    .except_code_o  (except_code_o)
  );

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_result(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: result %h, expected %h", $time, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_rob_idx(input alu_pkg::rob_idx_t got, input alu_pkg::rob_idx_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: rob index %0d, expected %0d", $time, got, exp);
      mismatch_cnt++;
    end
  endtask

  // Code only matters while the flag is raised
  task automatic check_except(input logic got_flag, input alu_pkg::except_code_t got_code,
                              input logic exp_flag);
    if (got_flag !== exp_flag) begin
      $display("[FAIL] %0t: exception flag %b, expected %b", $time, got_flag, exp_flag);
      mismatch_cnt++;
    end else if (exp_flag && got_code !== alu_pkg::E_ILLEGAL_INSTRUCTION) begin
      $display("[FAIL] %0t: exception code %0d, expected illegal instruction", $time,
               got_code);
      mismatch_cnt++;
    end
  endtask

  // Idle state after reset or flush
  task automatic check_idle_state(input string where);
    if (valid_o !== 1'b0 || ready_o !== 1'b1) begin
      $display("[FAIL] %0t: %s valid_o=%b ready_o=%b, expected 0 and 1", $time, where,
               valid_o, ready_o);
      state_err_cnt++;
    end
  endtask

  // Results still owed by the DUT
  function automatic int unsigned pending_cnt();
    int unsigned head;
    head = (chk_idx > skip_to) ? chk_idx : skip_to;
    return exp_q.size() - head;
  endfunction

  // --------------------------------------------------------------------------
  // Driver tasks, all stepping to 1 ns past the rising edge
  // --------------------------------------------------------------------------
  task automatic step_cycle(output bit took);
    @(posedge clk_i);
    // Handshake as seen at the edge
    took = valid_i && ready_o && !flush_i;
    #1;
    // Roughly 70 percent ready
    ready_i = ($urandom % 10) < 7;
  endtask

  task automatic send_op(input alu_pkg::alu_op_t op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic [XLEN-1:0] res,
                         input logic exc);
    bit          took;
    int unsigned waited;
    expect_t     e;
    took      = 1'b0;
    waited    = 0;
    valid_i   = 1'b1;
    op_i      = op;
    rob_idx_i = rob_ctr;
    rs1_i     = a;
    rs2_i     = b;
    while (!took && waited < ACCEPT_TIMEOUT) begin
      step_cycle(took);
      waited++;
    end
    valid_i = 1'b0;
    if (took) begin
      e.res           = res;
      e.rob_idx       = rob_ctr;
      e.except_raised = exc;
      exp_q.push_back(e);
      rob_ctr = rob_ctr + 1'b1;
    end else begin
      $display("Timeout: issue side never accepted operation with rob index %0d", rob_ctr);
      timeout_cnt++;
    end
  endtask

  task automatic apply_flush();
    bit took;
    // No output transfer on the flush edge
    ready_i = 1'b0;
    skip_to = exp_q.size();
    flush_i = 1'b1;
    // Offered with the flush, must be dropped
    valid_i = 1'b1;
    op_i    = alu_pkg::ALU_ADD;
    rs1_i   = '1;
    rs2_i   = '1;
    step_cycle(took);
    flush_i = 1'b0;
    valid_i = 1'b0;
    check_idle_state("after flush");
  endtask

  task automatic drain_results();
    bit          took;
    int unsigned waited;
    waited = 0;
    while (pending_cnt() != 0 && waited < DRAIN_TIMEOUT) begin
      step_cycle(took);
      waited++;
    end
    if (pending_cnt() != 0) begin
      $display("Timeout: %0d results never left the unit", pending_cnt());
      timeout_cnt++;
    end
    // A few more cycles to catch stray or duplicate results
    for (int i = 0; i < SETTLE_CYCLES; i++) begin
      step_cycle(took);
    end
  endtask

  // --------------------------------------------------------------------------
  // Result monitor
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (arst_n_i && valid_o && ready_i) begin
      if (chk_idx < skip_to) chk_idx = skip_to;
      if (chk_idx >= exp_q.size()) begin
        $display("Unexpected result at %0t with rob index %0d and nothing pending",
                 $time, rob_idx_o);
        extra_cnt++;
      end else begin
        check_result(result_o, exp_q[chk_idx].res);
        check_rob_idx(rob_idx_o, exp_q[chk_idx].rob_idx);
        check_except(except_raised_o, except_code_o, exp_q[chk_idx].except_raised);
        chk_idx++;
        checked_cnt++;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int              fd;
    int              n;
    bit              took;
    string           tok;
    string           rest;
    logic [3:0]      op_raw;
    logic [XLEN-1:0] g_rs1;
    logic [XLEN-1:0] g_rs2;
    logic [XLEN-1:0] g_res;
    logic            g_exc;
    arst_n_i  = 1'b0;
    flush_i   = 1'b0;
    valid_i   = 1'b0;
    op_i      = alu_pkg::ALU_ADD;
    rob_idx_i = '0;
    rs1_i     = '0;
    rs2_i     = '0;
    ready_i   = 1'b0;
    rob_ctr   = '0;
    void'($urandom(RAND_SEED));

    repeat (16) begin
      @(posedge clk_i);
      #1;
      check_idle_state("during reset");
    end
    arst_n_i = 1'b1;
    step_cycle(took);
    check_idle_state("after reset");

    fd = $fopen("tb/alu_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden vector file tb/alu_golden.txt");
      io_err_cnt++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          void'($fgets(rest, fd));
        end else if (tok == "FLUSH") begin
          apply_flush();
        end else begin
          n = $sscanf(tok, "%h", op_raw);
          n += $fscanf(fd, "%h %h %h %h", g_rs1, g_rs2, g_res, g_exc);
          if (n != 5) begin
            $display("Malformed golden vector line starting with %s", tok);
            io_err_cnt++;
          end else begin
            send_op(alu_pkg::alu_op_t'(op_raw), g_rs1, g_rs2, g_res, g_exc);
          end
        end
      end
      $fclose(fd);
    end
    drain_results();

    $display("Checked %0d, errors: %0d value, %0d state, %0d timeout, %0d extra, %0d file",
             checked_cnt, mismatch_cnt, state_err_cnt, timeout_cnt, extra_cnt, io_err_cnt);
    if (mismatch_cnt + state_err_cnt + timeout_cnt + extra_cnt + io_err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tb/alu_golden.txt */
# op rs1 rs2 result exc, all hex, op f is the unassigned opcode
# FLUSH line pulses flush_i while earlier operations are in flight
1 0000000000000010 0000000000000001 000000000000000f 0
6 00000000ffff0000 0000ffffffff0000 0000ffff00000000 0
FLUSH
0 0000000000000005 0000000000000007 000000000000000c 0
0 ffffffffffffffff 0000000000000002 0000000000000001 0
1 0000000000000003 0000000000000005 fffffffffffffffe 0
2 123456787fffffff 0000000000000001 ffffffff80000000 0
3 0000000100000005 0000000000000003 0000000000000002 0
4 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000 0
5 f0f0f0f0f0f0f0f0 0f0f0f0f00000000 fffffffff0f0f0f0 0
6 aaaaaaaaaaaaaaaa ffffffffffffffff 5555555555555555 0
7 0000000000000001 000000000000003f 8000000000000000 0
7 123456789abcdef0 0000000000000000 123456789abcdef0 0
8 8000000000000000 0000000000000020 0000000080000000 0
9 f000000000000000 000000000000001f ffffffffe0000000 0
a 0000000000000001 000000000000003f ffffffff80000000 0
b ffffffff80000000 0000000000000004 0000000008000000 0
c 0000000080000000 000000000000001f ffffffffffffffff 0
d ffffffffffffffff 0000000000000001 0000000000000001 0
e ffffffffffffffff 0000000000000001 0000000000000000 0
f 0123456789abcdef 0fedcba987654321 0000000000000000 1
